/* rtl/capture_pkg.sv */
package capture_pkg;

	// incoming audio samples are signed two's complement
	localparam int sample_width = 16;

	// one captured frame spans this many consecutive accepted samples
	localparam int frame_len = 256;

	// an in-frame index addresses every sample of a frame
	localparam int index_width = $clog2(frame_len);

	// each sample is kept as one offset-binary byte taken from its upper bits
	localparam int byte_width = 8;

	// the top address bit selects one of the two frame halves of the ping-pong buffer
	localparam int buf_addr_width = index_width + 1;

	// capture FSM
	// armed waits for a sample that is non-negative right after a negative one
	// active stores every valid sample until the frame is full
	// waiting holds the finished frame until the readout is idle and takes it
	typedef enum logic [1:0] {
		armed   = 2'b00,
		active  = 2'b01,
		waiting = 2'b10
	} capture_state_t;

	// the encoding 2'b11 is never entered, the FSM falls back to armed if it shows up

	// the readout walks the same frame length and index width, so a frame
	// written by capture is always read back in full

	// both sides keep their own half bit and flip it on the frame handshake,
	// which keeps capture and readout on opposite halves without a shared port

endpackage

/* rtl/display_pkg.sv */
package display_pkg;

	// the horizontal coordinate is the sample's position inside its frame
	localparam int point_x_width = capture_pkg::index_width;

	// the vertical coordinate is the stored byte itself
	localparam int point_y_width = capture_pkg::byte_width;

	// adding this to the signed upper byte gives offset binary
	// so a zero sample lands in the middle of the screen
	localparam logic [point_y_width-1:0] y_bias = {1'b1, {(point_y_width - 1){1'b0}}};

	// a point with the most negative sample draws at y == 0 and the most
	// positive one at y == 255, x runs left to right across one frame

	// the first point of a frame always has x == 0 and holds the crossing sample

	// the last point of a frame has x == 2**point_x_width - 1, the display
	// can use it to know that the trace is complete

	// points travel under valid/ready, the coordinates stay stable while a
	// point is offered and not yet taken

endpackage

/* rtl/wave_capture.sv */
`timescale 1ns/1ns

module wave_capture import capture_pkg::*; (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           sample_valid,
	input  logic signed [sample_width-1:0] sample,
	input  logic                           frame_ready,
	output logic                           frame_valid,
	output logic                           wr_en,
	output logic [buf_addr_width-1:0]      wr_addr,
	output logic [byte_width-1:0]          wr_data
);

	capture_state_t         state;
	logic                   last_negative; // sign of the previous valid sample
	logic [index_width-1:0] count;         // in-frame index of the next write
	logic                   wr_half;       // half of the buffer that is being filled
	logic                   is_negative;   // sign of the sample on the input right now
	logic                   crossing;      // positive zero crossing on this cycle
	logic                   count_last;    // the next write completes the frame

	// the sign bit of a two's complement sample is its top bit
	assign is_negative = sample[sample_width-1];

	// only a valid sample can form a crossing, and only against a valid predecessor
	assign crossing = sample_valid && last_negative && !is_negative;

	assign count_last = (count == index_width'(frame_len - 1));

	// the crossing sample itself is stored, it becomes index 0 of the frame
	assign wr_en = (state == armed && crossing) || (state == active && sample_valid);

	// count is zero while armed, so the crossing write lands at the base of the half
	assign wr_addr = {wr_half, count};

	// upper byte plus 128 is the same as flipping the sign bit of that byte
	assign wr_data = {~sample[sample_width-1], sample[sample_width-2 -: byte_width-1]};

	assign frame_valid = (state == waiting); // a full frame sits in wr_half

	// sign history follows every valid sample, whatever the state
	always_ff @(posedge clk) begin
		if (reset) begin
			last_negative <= 1'b0; // no crossing can fire on the first sample after reset
		end else if (sample_valid) begin
			last_negative <= is_negative;
		end
	end

	// the counter steps on each write and wraps to zero on the last one
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (wr_en) begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= armed;
			wr_half <= 1'b0;
		end else begin
			case (state)
				armed: begin
					if (crossing) begin
						state <= active; // index 0 is written on this same cycle
					end
				end
				active: begin
					if (sample_valid && count_last) begin
						state <= waiting; // the 256th write just went out
					end
				end
				waiting: begin
					// readout takes this half, capture moves to the other one
					if (frame_ready) begin
						state   <= armed;
						wr_half <= ~wr_half;
					end
				end
				default: begin
					state <= armed;
				end
			endcase
		end
	end

	// only the crossing write of a frame lands on index 0, the active writes fill 1 to 255
	a_write_index: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (state == armed) == (count == '0));

	// every frame starts at index 0, so the counter must have wrapped before rearming
	a_armed_count_zero: assert property (@(posedge clk) disable iff (reset)
		state == armed |-> count == '0);

endmodule

/* rtl/wave_ram.sv */
`timescale 1ns/1ns

module wave_ram import capture_pkg::*; (
	input  logic                      clk,
	input  logic                      wr_en,
	input  logic [buf_addr_width-1:0] wr_addr,
	input  logic [byte_width-1:0]     wr_data,
	input  logic                      rd_en,
	input  logic [buf_addr_width-1:0] rd_addr,
	output logic [byte_width-1:0]     rd_data
);

	// both frame halves share one array, the top address bit picks the half
	logic [byte_width-1:0] mem [0:2**buf_addr_width-1];

	// write port, capture stores one byte per accepted sample
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read port
	// the output keeps its last value while rd_en is low, which lets the readout
	// stall without issuing the same read again
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	// capture and readout always work on opposite halves, so a read never
	// sees a byte that is being overwritten on the same cycle
	a_halves_apart: assert property (@(posedge clk)
		wr_en && rd_en |-> wr_addr[buf_addr_width-1] != rd_addr[buf_addr_width-1]);

endmodule

/* rtl/wave_readout.sv */
`timescale 1ns/1ns

module wave_readout import capture_pkg::*, display_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      frame_valid,
	output logic                      frame_ready,
	output logic                      rd_en,
	output logic [buf_addr_width-1:0] rd_addr,
	input  logic [byte_width-1:0]     rd_data,
	output logic                      in_valid,
	input  logic                      in_ready,
	output logic [point_x_width-1:0]  in_x,
	output logic [point_y_width-1:0]  in_y
);

	logic                   busy;       // a frame is being walked
	logic                   rd_half;    // flips on every frame transfer, like the capture half
	logic [index_width-1:0] rd_idx;     // next index to fetch from the buffer
	logic                   issued_all; // the read of the last index has gone out
	logic                   pending;    // rd_data holds a point the skid has not taken yet
	logic                   take;       // the skid accepts the pending point on this cycle

	assign frame_ready = !busy; // idle means the previous frame has fully left

	assign take = pending && in_ready;

	// a new read is allowed once the ram output register is free or being emptied
	// so there is never more than one read in flight
	assign rd_en = busy && !issued_all && (!pending || in_ready);

	// rd_half already flipped on the transfer, the frame to read sits in the other half
	assign rd_addr = {~rd_half, rd_idx};

	assign in_valid = pending;
	assign in_y     = rd_data; // held by the ram while rd_en stays low

	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			rd_half    <= 1'b0;
			rd_idx     <= '0;
			issued_all <= 1'b0;
			pending    <= 1'b0;
		end else if (!busy) begin
			// frame handshake, capture flips its own half on this same edge
			if (frame_valid) begin
				busy       <= 1'b1;
				rd_half    <= ~rd_half;
				rd_idx     <= '0;
				issued_all <= 1'b0;
			end
		end else if (rd_en) begin
			rd_idx  <= rd_idx + 1'b1;
			pending <= 1'b1; // data shows up next cycle, any old point was just taken
			if (rd_idx == index_width'(frame_len - 1)) begin
				issued_all <= 1'b1;
			end
		end else if (take) begin
			pending <= 1'b0;
			if (in_x == point_x_width'(frame_len - 1)) begin
				busy <= 1'b0; // last point of the frame went to the skid
			end
		end
	end

	// x of the point that is loading into the ram output register
	always_ff @(posedge clk) begin
		if (rd_en) begin
			in_x <= rd_idx;
		end
	end

	// between frames no point is offered, so every frame starts with an empty ram register
	a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
		frame_ready |-> !in_valid);

endmodule

/* rtl/point_skid.sv */
`timescale 1ns/1ns

module point_skid import display_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [point_x_width-1:0] in_x,
	input  logic [point_y_width-1:0] in_y,
	output logic                     point_valid,
	input  logic                     point_ready,
	output logic [point_x_width-1:0] point_x,
	output logic [point_y_width-1:0] point_y
);

	logic                     spare_valid; // a point is parked behind the output register
	logic [point_x_width-1:0] spare_x;
	logic [point_y_width-1:0] spare_y;
	logic                     out_free;    // the output register can load this cycle
	logic                     in_take;     // upstream point accepted this cycle

	// ready comes straight from a flop, point_ready never reaches upstream in one cycle
	assign in_ready = !spare_valid;
	assign in_take  = in_valid && in_ready;
	assign out_free = !point_valid || point_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			point_valid <= 1'b0;
			spare_valid <= 1'b0;
		end else if (out_free) begin
			// the spare drains first, upstream is held off while it is full
			point_valid <= spare_valid || in_take;
			spare_valid <= 1'b0;
		end else if (in_take) begin
			spare_valid <= 1'b1; // output is stalled, park the new point
		end
	end

	// coordinates only, no control in here
	always_ff @(posedge clk) begin
		if (out_free) begin
			point_x <= spare_valid ? spare_x : in_x;
			point_y <= spare_valid ? spare_y : in_y;
		end
		if (!out_free && in_take) begin
			spare_x <= in_x;
			spare_y <= in_y;
		end
	end

	// a stalled point stays on the wires unchanged until the display takes it
	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		point_valid && !point_ready |=> point_valid && $stable(point_x) && $stable(point_y));

endmodule

/* rtl/scope_top.sv */
`timescale 1ns/1ns

module scope_top import capture_pkg::*, display_pkg::*; (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           sample_valid,
	input  logic signed [sample_width-1:0] sample,
	output logic                           point_valid,
	input  logic                           point_ready,
	output logic [point_x_width-1:0]       point_x,
	output logic [point_y_width-1:0]       point_y
);

	// frame handshake between capture and readout
	logic                      frame_valid;
	logic                      frame_ready;

	// buffer ports
	logic                      wr_en;
	logic [buf_addr_width-1:0] wr_addr;
	logic [byte_width-1:0]     wr_data;
	logic                      rd_en;
	logic [buf_addr_width-1:0] rd_addr;
	logic [byte_width-1:0]     rd_data;

	// readout to skid
	logic                      in_valid;
	logic                      in_ready;
	logic [point_x_width-1:0]  in_x;
	logic [point_y_width-1:0]  in_y;

	wave_capture i_wave_capture (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.frame_ready  (frame_ready),
		.frame_valid  (frame_valid),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data)
	);

	wave_ram i_wave_ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	wave_readout i_wave_readout (
		.clk         (clk),
		.reset       (reset),
		.frame_valid (frame_valid),
		.frame_ready (frame_ready),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_x        (in_x),
		.in_y        (in_y)
	);

	point_skid i_point_skid (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_x        (in_x),
		.in_y        (in_y),
		.point_valid (point_valid),
		.point_ready (point_ready),
		.point_x     (point_x),
		.point_y     (point_y)
	);

endmodule

/* verif/scope_tb.sv */
`timescale 1ns/1ns

module scope_tb import capture_pkg::*, display_pkg::*; ();

	localparam int frames_to_run = 6;
	localparam int max_cycles    = 20000; // six frames at up to about 2500 cycles each plus margin
	localparam int guard_points  = 250;   // past this point the DUT readout may already be idle

	logic                           clk;
	logic                           reset;
	logic                           sample_valid;
	logic signed [sample_width-1:0] sample;
	logic                           point_valid;
	logic                           point_ready;
	logic [point_x_width-1:0]       point_x;
	logic [point_y_width-1:0]       point_y;

	// reference model of the capture rules, updated once per rising edge
	capture_state_t           m_state;
	logic                     m_last_neg;      // sign of the last valid sample
	int                       m_count;         // writes done in the frame being captured
	logic                     m_idle;          // readout has no frame, set when x == 255 leaves
	logic [point_y_width-1:0] exp_q [$];       // expected y values of all captured frames in order
	int                       exp_x;           // x of the next point to leave the DUT
	logic                     head_avail;      // at least one point is owed by the DUT
	logic [point_x_width-1:0] head_x;
	logic [point_y_width-1:0] head_y;
	int                       frames_captured;
	int                       points_seen;

	int                             errors = 0;
	int                             cycles = 0;
	string                          test_name;
	logic                           quiet;          // no point may appear while this is set
	logic signed [sample_width-1:0] saw;            // sawtooth source, wraps through zero

	scope_top i_scope_top (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.point_valid  (point_valid),
		.point_ready  (point_ready),
		.point_x      (point_x),
		.point_y      (point_y)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// run limit, a lost or stuck frame ends up here
	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	always @(posedge clk) begin : ref_model
		logic           neg;
		logic           crossing;
		logic           write;
		logic           transfer;
		capture_state_t prev;
		if (reset) begin
			m_state         = armed;
			m_last_neg      = 1'b0;
			m_count         = 0;
			m_idle          = 1'b1;
			exp_x           = 0;
			frames_captured = 0;
			points_seen     = 0;
			exp_q.delete();
		end else begin
			prev     = m_state;
			transfer = (prev == waiting) && m_idle; // uses the idle flag from before this edge
			neg      = sample[sample_width-1];
			crossing = sample_valid && m_last_neg && !neg;
			write    = (prev == armed && crossing) || (prev == active && sample_valid);

			// a point leaving the DUT retires the head of the expected stream
			if (point_valid && point_ready) begin
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
				end
				points_seen++;
				if (exp_x == frame_len - 1) begin
					m_idle = 1'b1; // the whole frame has left, readout can take the next one
				end
				exp_x = (exp_x + 1) % frame_len;
			end

			if (prev == armed && crossing) begin
				m_state = active;
			end
			if (transfer) begin
				m_state = armed;
				m_idle  = 1'b0;
			end
			if (write) begin
				// upper byte plus the bias gives the offset-binary screen position
				exp_q.push_back(sample[sample_width-1 -: point_y_width] + y_bias);
				m_count++;
				if (m_count == frame_len) begin
					m_count = 0;
					m_state = waiting;
					frames_captured++;
				end
			end
			if (sample_valid) begin
				m_last_neg = neg; // sign history follows every valid sample
			end
		end
		head_avail = exp_q.size() > 0;
		head_x     = point_x_width'(exp_x);
		head_y     = head_avail ? exp_q[0] : '0;
	end

	a_quiet: assert property (@(posedge clk) disable iff (reset) quiet |-> !point_valid)
		else begin
			errors++;
			$display("[ERROR] %s: point_valid expected 0 actual %0b", test_name,
				$sampled(point_valid));
		end

	a_point_owed: assert property (@(posedge clk) disable iff (reset)
		point_valid && point_ready |-> head_avail)
		else begin
			errors++;
			$display("%s: a point left the DUT with no captured sample behind it", test_name);
		end

	a_point_x: assert property (@(posedge clk) disable iff (reset)
		point_valid && point_ready && head_avail |-> point_x == head_x)
		else begin
			errors++;
			$display("[ERROR] %s: point_x expected %0d actual %0d", test_name,
				$sampled(head_x), $sampled(point_x));
		end

	a_point_y: assert property (@(posedge clk) disable iff (reset)
		point_valid && point_ready && head_avail |-> point_y == head_y)
		else begin
			errors++;
			$display("[ERROR] %s: point_y at x %0d expected %0h actual %0h", test_name,
				$sampled(head_x), $sampled(head_y), $sampled(point_y));
		end

	// a stalled point has to stay on the wires unchanged
	a_stall_hold: assert property (@(posedge clk) disable iff (reset)
		point_valid && !point_ready |=> point_valid && $stable(point_x) && $stable(point_y))
		else begin
			errors++;
			$display("%s: the point dropped or changed while point_ready was low", test_name);
		end

	// inputs change 1 ns after the edge, the display is slow most of the time
	task automatic next_cycle();
		@(posedge clk);
		#1;
		point_ready = ($urandom % 8) < 3;
	endtask

	// near a frame swap the DUT may already be armed while the model still waits
	function automatic logic near_frame_swap();
		return m_state == waiting && (m_idle || exp_x >= guard_points);
	endfunction

	initial begin
		int i;
		reset        = 1'b1;
		sample_valid = 1'b0;
		sample       = '0;
		point_ready  = 1'b0;
		quiet        = 1'b1;
		test_name    = "reset";
		saw          = -16'sd20000;
		void'($urandom(32'he042));
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// positive samples right after reset then only negative ones, no crossing anywhere
		test_name = "no_trigger";
		for (i = 0; i < 200; i++) begin
			next_cycle();
			sample_valid = ($urandom % 4) != 0;
			if (i < 40) begin
				sample = sample_width'($urandom % 32768);
			end else begin
				sample = -sample_width'(1 + ($urandom % 32767));
			end
		end

		// sawtooth with random gaps, frames overlap with the drain of the one before
		test_name = "ping_pong_frames";
		quiet     = 1'b0;
		while (frames_captured < frames_to_run) begin
			next_cycle();
			if (near_frame_swap() || ($urandom % 4) == 0) begin
				sample_valid = 1'b0;
			end else begin
				sample_valid = 1'b1;
				saw          = saw + sample_width'($urandom_range(600, 150));
				sample       = saw;
			end
		end
		sample_valid = 1'b0;

		test_name = "drain";
		while (points_seen < frames_to_run * frame_len) begin
			next_cycle();
		end
		repeat (20) next_cycle(); // an extra point would show up here

		a_point_count: assert (points_seen == frames_to_run * frame_len && exp_q.size() == 0)
			else begin
				errors++;
				$display("[ERROR] %s: points expected %0d actual %0d", test_name,
					frames_to_run * frame_len, points_seen);
			end

		$display("checked %0d points in %0d frames, %0d errors", points_seen,
			frames_captured, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
// packages first, capture_pkg before display_pkg which refers to it
rtl/capture_pkg.sv
rtl/display_pkg.sv
// design, leaf modules before the top level
rtl/wave_capture.sv
rtl/wave_ram.sv
rtl/wave_readout.sv
rtl/point_skid.sv
rtl/scope_top.sv
// testbench
verif/scope_tb.sv
